/* verilog/csi2_pkg.sv */
package csi2_pkg;

  typedef logic [7 : 0]  lane_byte_t;
  typedef logic [15 : 0] pixel_word_t;
  typedef logic [7 : 0]  data_id_t;
  typedef logic [15 : 0] word_count_t;
  typedef logic [5 : 0]  ecc_t;
  typedef logic [2 : 0]  credit_t;

  localparam int         LANE_COUNT     = 2;
  localparam lane_byte_t SYNC_BYTE      = 8'hB8;
  localparam data_id_t   DI_FRAME_START = 8'h00;
  localparam data_id_t   DI_FRAME_END   = 8'h01;
  localparam data_id_t   DI_RAW8        = 8'h2A;
  localparam int         FIFO_DEPTH     = 8;
  localparam int         FIFO_AW        = $clog2( FIFO_DEPTH );
  localparam credit_t    CREDIT_INIT    = 3'd4;

  typedef enum logic [1 : 0] {
    PS_IDLE,
    PS_HEADER,
    PS_PAYLOAD,
    PS_CRC
  } parser_state_t;

  // Hamming parity of the CSI-2 packet header, D[7:0] is the data identifier.
  function automatic ecc_t csi2_ecc( input logic [23 : 0] d );
    ecc_t p;
    p[0] = d[0]  ^ d[1]  ^ d[2]  ^ d[4]  ^ d[5]  ^ d[7]  ^ d[10] ^
           d[11] ^ d[13] ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    p[1] = d[0]  ^ d[1]  ^ d[3]  ^ d[4]  ^ d[6]  ^ d[8]  ^ d[10] ^
           d[12] ^ d[14] ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    p[2] = d[0]  ^ d[2]  ^ d[3]  ^ d[5]  ^ d[6]  ^ d[9]  ^ d[11] ^
           d[12] ^ d[15] ^ d[18] ^ d[20] ^ d[21] ^ d[22];
    p[3] = d[1]  ^ d[2]  ^ d[3]  ^ d[7]  ^ d[8]  ^ d[9]  ^ d[13] ^
           d[14] ^ d[15] ^ d[19] ^ d[20] ^ d[21] ^ d[23];
    p[4] = d[4]  ^ d[5]  ^ d[6]  ^ d[7]  ^ d[8]  ^ d[9]  ^ d[16] ^
           d[17] ^ d[18] ^ d[19] ^ d[20] ^ d[22] ^ d[23];
    p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^
           d[17] ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
    return p;
  endfunction

endpackage

/* verilog/btn_edge_detect.sv */
module btn_edge_detect import csi2_pkg::*;
(
  input                             ref_clk_i,
  input                             ref_srst_i,
  input        [LANE_COUNT - 1 : 0] btn_i,
  output logic [LANE_COUNT - 1 : 0] slip_o
);

logic [LANE_COUNT - 1 : 0] btn_d1;
logic [LANE_COUNT - 1 : 0] btn_d2;
logic [LANE_COUNT - 1 : 0] btn_d3;

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      btn_d1 <= '0;
      btn_d2 <= '0;
      btn_d3 <= '0;
      slip_o <= '0;
    end
  else
    begin
      btn_d1 <= btn_i;
      btn_d2 <= btn_d1;
      btn_d3 <= btn_d2;
      slip_o <= btn_d2 & ~btn_d3; // Rising edge, one pulse per press.
    end

endmodule

/* verilog/lane_bit_aligner.sv */
module lane_bit_aligner import csi2_pkg::*;
(
  input              ref_clk_i,
  input              ref_srst_i,
  input  lane_byte_t raw_byte_i,
  input              hs_valid_i,
  input              slip_i,
  output lane_byte_t byte_o,
  output logic       valid_o,
  output logic       synced_o
);

logic [2 : 0]  offset_q;
lane_byte_t    prev_q;
logic [15 : 0] window;
logic [3 : 0]  sel_base;
lane_byte_t    sel_byte;

// Offset k takes the top k bits of the previous byte as the low bits.
assign window   = { raw_byte_i, prev_q };
assign sel_base = 4'd8 - { 1'b0, offset_q };
assign sel_byte = window[sel_base +: 8];

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      offset_q <= '0;
      synced_o <= 1'b0;
      valid_o  <= 1'b0;
    end
  else
    begin
      if( slip_i )
        offset_q <= offset_q + 3'd1; // Wraps modulo 8.

      if( !hs_valid_i )
        begin
          synced_o <= 1'b0;
          valid_o  <= 1'b0;
        end
      else
        begin
          valid_o <= synced_o;       // The sync byte itself stays invalid.
          if( !synced_o && ( sel_byte == SYNC_BYTE ) )
            synced_o <= 1'b1;
        end
    end

always_ff @( posedge ref_clk_i )
  if( hs_valid_i )
    begin
      prev_q <= raw_byte_i;
      byte_o <= sel_byte;
    end

endmodule

/* verilog/lane_merger.sv */
module lane_merger import csi2_pkg::*;
(
  input               ref_clk_i,
  input               ref_srst_i,
  input  lane_byte_t  lane0_byte_i,
  input               lane0_valid_i,
  input  lane_byte_t  lane1_byte_i,
  input               lane1_valid_i,
  output pixel_word_t pair_o,
  output logic        pair_valid_o,
  output logic        pair_start_o
);

lane_byte_t                in_byte [LANE_COUNT];
logic [LANE_COUNT - 1 : 0] in_valid;
lane_byte_t                hold_q  [LANE_COUNT][2];
logic [1 : 0]              cnt_q   [LANE_COUNT];
lane_byte_t                head    [LANE_COUNT];
logic [LANE_COUNT - 1 : 0] avail;
logic [LANE_COUNT - 1 : 0] empty;
logic                      take;
logic                      idle;
logic                      active_q;

assign in_byte[0] = lane0_byte_i;
assign in_byte[1] = lane1_byte_i;
assign in_valid   = { lane1_valid_i, lane0_valid_i };

always_comb
  for( int l = 0; l < LANE_COUNT; l++ )
    begin
      empty[l] = ( cnt_q[l] == 2'd0 );
      avail[l] = !empty[l] || in_valid[l];
      head[l]  = empty[l] ? in_byte[l] : hold_q[l][0]; // Oldest byte first.
    end

assign take = &avail;
assign idle = !( |in_valid ) && ( &empty );

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      for( int l = 0; l < LANE_COUNT; l++ )
        cnt_q[l] <= '0;
      active_q     <= 1'b0;
      pair_valid_o <= 1'b0;
      pair_start_o <= 1'b0;
    end
  else
    begin
      for( int l = 0; l < LANE_COUNT; l++ )
        if( take && !in_valid[l] )
          cnt_q[l] <= cnt_q[l] - 2'd1;
        else if( !take && in_valid[l] && ( cnt_q[l] != 2'd2 ) )
          cnt_q[l] <= cnt_q[l] + 2'd1;

      if( take )
        active_q <= 1'b1;
      else if( idle )
        active_q <= 1'b0;                           // Gap between transmissions.

      pair_valid_o <= take;
      pair_start_o <= take && !active_q;
    end

always_ff @( posedge ref_clk_i )
  begin
    for( int l = 0; l < LANE_COUNT; l++ )
      if( take && !empty[l] )
        begin
          hold_q[l][0] <= in_valid[l] && ( cnt_q[l] == 2'd1 ) ? in_byte[l] : hold_q[l][1];
          hold_q[l][1] <= in_byte[l];
        end
      else if( !take && in_valid[l] )
        hold_q[l][cnt_q[l][0]] <= in_byte[l];      // Extra bytes past two are lost.

    if( take )
      pair_o <= { head[1], head[0] };
  end

endmodule

/* verilog/packet_parser.sv */
module packet_parser import csi2_pkg::*;
(
  input               ref_clk_i,
  input               ref_srst_i,
  input  pixel_word_t pair_i,
  input               pair_valid_i,
  input               pair_start_i,
  output pixel_word_t pixel_o,
  output logic        user_o,
  output logic        last_o,
  output logic        push_o,
  output logic        ecc_error_o
);

parser_state_t state_q;
pixel_word_t   hdr_q;
word_count_t   remain_q;
logic          user_armed_q;
data_id_t      hdr_di;
word_count_t   hdr_wc;
logic          ecc_ok;
logic          push_en;
logic          last_word;
logic          hdr_done;

// First pair holds DI and WC low, the second holds WC high and the ECC.
assign hdr_di    = hdr_q[7 : 0];
assign hdr_wc    = { pair_i[7 : 0], hdr_q[15 : 8] };
assign ecc_ok    = ( csi2_ecc( { pair_i[7 : 0], hdr_q } ) == ecc_t'( pair_i[13 : 8] ) );
assign hdr_done  = pair_valid_i && !pair_start_i && ( state_q == PS_HEADER );
assign push_en   = pair_valid_i && !pair_start_i && ( state_q == PS_PAYLOAD );
assign last_word = ( remain_q <= word_count_t'( 2 ) );

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      state_q      <= PS_IDLE;
      user_armed_q <= 1'b0;
      push_o       <= 1'b0;
      ecc_error_o  <= 1'b0;
    end
  else
    begin
      push_o      <= push_en;
      ecc_error_o <= 1'b0;
      if( pair_valid_i && pair_start_i )
        state_q <= PS_HEADER;                      // Every transmission opens with a header.
      else if( pair_valid_i )
        case( state_q )
          PS_HEADER:
            begin
              state_q <= PS_IDLE;
              if( !ecc_ok )
                ecc_error_o <= 1'b1;
              else if( hdr_di == DI_FRAME_START )
                user_armed_q <= 1'b1;
              else if( hdr_di == DI_FRAME_END )
                user_armed_q <= 1'b0;
              else if( hdr_di == DI_RAW8 )
                state_q <= ( hdr_wc == '0 ) ? PS_CRC : PS_PAYLOAD;
            end
          PS_PAYLOAD:
            begin
              user_armed_q <= 1'b0;                // Only the first word of the frame.
              if( last_word )
                state_q <= PS_CRC;
            end
          PS_CRC:
            state_q <= PS_IDLE;                    // Both CRC bytes arrive as one pair.
          default:
            state_q <= PS_IDLE;
        endcase
    end

always_ff @( posedge ref_clk_i )
  begin
    if( pair_valid_i && pair_start_i )
      hdr_q <= pair_i;
    if( hdr_done )
      remain_q <= hdr_wc;
    else if( push_en )
      remain_q <= remain_q - word_count_t'( 2 );
    if( push_en )
      begin
        pixel_o <= pair_i;
        user_o  <= user_armed_q;
        last_o  <= last_word;
      end
  end

endmodule

/* verilog/credit_tx.sv */
module credit_tx import csi2_pkg::*;
(
  input               ref_clk_i,
  input               ref_srst_i,
  input  pixel_word_t pixel_i,
  input               user_i,
  input               last_i,
  input               push_i,
  input               credit_return_i,
  output pixel_word_t video_data_o,
  output logic        video_user_o,
  output logic        video_last_o,
  output logic        video_valid_o,
  output logic        overflow_o
);

logic [17 : 0]          mem_q [FIFO_DEPTH];
logic [FIFO_AW - 1 : 0] wr_ptr_q;
logic [FIFO_AW - 1 : 0] rd_ptr_q;
logic [FIFO_AW : 0]     count_q;
credit_t                credit_q;
logic                   full;
logic                   wr_en;
logic                   send;

assign full  = ( count_q == ( FIFO_AW + 1 )'( FIFO_DEPTH ) );
assign wr_en = push_i && !full;
assign send  = ( count_q != '0 ) && ( credit_q != '0 );

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      credit_q      <= CREDIT_INIT;
      video_valid_o <= 1'b0;
      overflow_o    <= 1'b0;
    end
  else
    begin
      if( wr_en )
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if( send )
        rd_ptr_q <= rd_ptr_q + 1'b1;

      case( { wr_en, send } )
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase

      credit_q      <= credit_q - credit_t'( send ) + credit_t'( credit_return_i );
      video_valid_o <= send;
      if( push_i && full )
        overflow_o <= 1'b1;                        // Sticky until reset.
    end

always_ff @( posedge ref_clk_i )
  begin
    if( wr_en )
      mem_q[wr_ptr_q] <= { user_i, last_i, pixel_i };
    if( send )
      { video_user_o, video_last_o, video_data_o } <= mem_q[rd_ptr_q];
  end

endmodule

/* verilog/csi2_rx_top.sv */
module csi2_rx_top import csi2_pkg::*;
(
  input                                   ref_clk_i,
  input                                   ref_srst_i,
  input        [LANE_COUNT - 1 : 0]       btn_i,
  input  lane_byte_t [LANE_COUNT - 1 : 0] lane_raw_i,
  input        [LANE_COUNT - 1 : 0]       lane_hs_valid_i,
  input                                   credit_return_i,
  output pixel_word_t                     video_data_o,
  output                                  video_user_o,
  output                                  video_last_o,
  output                                  video_valid_o,
  output                                  ecc_error_o,
  output                                  overflow_o
);

logic [LANE_COUNT - 1 : 0] slip_pulse;
lane_byte_t                lane0_byte;
lane_byte_t                lane1_byte;
logic                      lane0_valid;
logic                      lane1_valid;
pixel_word_t               pair_data;
logic                      pair_valid;
logic                      pair_start;
pixel_word_t               pixel;
logic                      pixel_user;
logic                      pixel_last;
logic                      pixel_push;

btn_edge_detect btn_edge_detect (
  .ref_clk_i       ( ref_clk_i          ),
  .ref_srst_i      ( ref_srst_i         ),
  .btn_i           ( btn_i              ),
  .slip_o          ( slip_pulse         )
);

lane_bit_aligner lane0_aligner (
  .ref_clk_i       ( ref_clk_i          ),
  .ref_srst_i      ( ref_srst_i         ),
  .raw_byte_i      ( lane_raw_i[0]      ),
  .hs_valid_i      ( lane_hs_valid_i[0] ),
  .slip_i          ( slip_pulse[0]      ),
  .byte_o          ( lane0_byte         ),
  .valid_o         ( lane0_valid        ),
  .synced_o        (                    )
);

lane_bit_aligner lane1_aligner (
  .ref_clk_i       ( ref_clk_i          ),
  .ref_srst_i      ( ref_srst_i         ),
  .raw_byte_i      ( lane_raw_i[1]      ),
  .hs_valid_i      ( lane_hs_valid_i[1] ),
  .slip_i          ( slip_pulse[1]      ),
  .byte_o          ( lane1_byte         ),
  .valid_o         ( lane1_valid        ),
  .synced_o        (                    )
);

lane_merger lane_merger (
  .ref_clk_i       ( ref_clk_i          ),
  .ref_srst_i      ( ref_srst_i         ),
  .lane0_byte_i    ( lane0_byte         ),
  .lane0_valid_i   ( lane0_valid        ),
  .lane1_byte_i    ( lane1_byte         ),
  .lane1_valid_i   ( lane1_valid        ),
  .pair_o          ( pair_data          ),
  .pair_valid_o    ( pair_valid         ),
  .pair_start_o    ( pair_start         )
);

packet_parser packet_parser (
  .ref_clk_i       ( ref_clk_i          ),
  .ref_srst_i      ( ref_srst_i         ),
  .pair_i          ( pair_data          ),
  .pair_valid_i    ( pair_valid         ),
  .pair_start_i    ( pair_start         ),
  .pixel_o         ( pixel              ),
  .user_o          ( pixel_user         ),
  .last_o          ( pixel_last         ),
  .push_o          ( pixel_push         ),
  .ecc_error_o     ( ecc_error_o        )
);

credit_tx credit_tx (
  .ref_clk_i       ( ref_clk_i          ),
  .ref_srst_i      ( ref_srst_i         ),
  .pixel_i         ( pixel              ),
  .user_i          ( pixel_user         ),
  .last_i          ( pixel_last         ),
  .push_i          ( pixel_push         ),
  .credit_return_i ( credit_return_i    ),
  .video_data_o    ( video_data_o       ),
  .video_user_o    ( video_user_o       ),
  .video_last_o    ( video_last_o       ),
  .video_valid_o   ( video_valid_o      ),
  .overflow_o      ( overflow_o         )
);

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen
(
  output logic clk_o
);

initial
  begin
    clk_o = 1'b0;
    forever
      #5 clk_o = ~clk_o;       // Period of 10.
  end

endmodule

/* testbench/csi2_rx_assertions.sv */
module csi2_rx_assertions import csi2_pkg::*;
(
  input          ref_clk_i,
  input          ref_srst_i,
  input          video_valid_i,
  input credit_t credit_i
);

int fail_count = 0;

// A word only leaves when a credit was held in the cycle before.
valid_needs_credit: assert property (
  @( posedge ref_clk_i ) disable iff ( ref_srst_i )
  video_valid_i |-> ( $past( credit_i ) != '0 ) )
  else
    begin
      $error( "video_valid_o rose with no credit left" );
      fail_count++;
    end

credit_bounded: assert property (
  @( posedge ref_clk_i ) disable iff ( ref_srst_i )
  credit_i <= CREDIT_INIT )
  else
    begin
      $error( "credit count above the initial grant" );
      fail_count++;
    end

valid_known: assert property (
  @( posedge ref_clk_i ) disable iff ( ref_srst_i )
  !$isunknown( video_valid_i ) )
  else
    begin
      $error( "video_valid_o is unknown" );
      fail_count++;
    end

endmodule

/* testbench/csi2_rx_tb.sv */
module csi2_rx_tb import csi2_pkg::*;
();

typedef lane_byte_t byte_q_t[$];

typedef struct {
  int       off0;
  int       off1;
  int       skew;
  data_id_t di;
  int       wc;
  bit       corrupt;
  bit       reuse;
  int       period;      // 0 holds credits back until the line is in.
  int       exp_words;
  int       exp_user;
  int       exp_last;
  int       exp_ecc;
  bit       exp_ovf;
  string    name;
} row_t;

localparam int ROWS = 9;

logic                          ref_clk_i;
logic                          ref_srst_i;
logic [LANE_COUNT - 1 : 0]     btn_i;
lane_byte_t [LANE_COUNT - 1 : 0] lane_raw_i;
logic [LANE_COUNT - 1 : 0]     lane_hs_valid_i;
logic                          credit_return_i;
pixel_word_t                   video_data_o;
logic                          video_user_o;
logic                          video_last_o;
logic                          video_valid_o;
logic                          ecc_error_o;
logic                          overflow_o;

row_t          rows [ROWS];
logic [17 : 0] exp_q [$];
byte_q_t       payload;
int            errors;
int            cur_off [LANE_COUNT];
int            words_total;
int            user_total;
int            last_total;
int            ecc_total;
int            returned_total;
int            owed;
int            sink_cycle;
int            credit_period;
bit            credit_hold;

tb_clock_gen clock_gen ( .clk_o( ref_clk_i ) );

csi2_rx_top UUT (
  .ref_clk_i       ( ref_clk_i       ),
  .ref_srst_i      ( ref_srst_i      ),
  .btn_i           ( btn_i           ),
  .lane_raw_i      ( lane_raw_i      ),
  .lane_hs_valid_i ( lane_hs_valid_i ),
  .credit_return_i ( credit_return_i ),
  .video_data_o    ( video_data_o    ),
  .video_user_o    ( video_user_o    ),
  .video_last_o    ( video_last_o    ),
  .video_valid_o   ( video_valid_o   ),
  .ecc_error_o     ( ecc_error_o     ),
  .overflow_o      ( overflow_o      )
);

bind credit_tx csi2_rx_assertions credit_checks (
  .ref_clk_i     ( ref_clk_i     ),
  .ref_srst_i    ( ref_srst_i    ),
  .video_valid_i ( video_valid_o ),
  .credit_i      ( credit_q      )
);

task automatic compare_values( input string what, input int actual, input int expected );
  if( actual != expected )
    begin
      $display( "Error at %0t: %s got 0x%0h, expected 0x%0h", $time, what, actual, expected );
      errors++;
    end
endtask

task automatic load_table();
  rows[0] = '{0, 0, 0, DI_FRAME_START, 0,  1'b0, 1'b0, 1, 0,  0, 0, 0, 1'b0, "frame start"};
  rows[1] = '{3, 5, 0, DI_RAW8,        16, 1'b0, 1'b0, 1, 8,  1, 1, 0, 1'b0, "aligned line"};
  rows[2] = '{3, 5, 1, DI_RAW8,        16, 1'b0, 1'b1, 1, 8,  0, 1, 0, 1'b0, "skew one"};
  rows[3] = '{3, 5, 2, DI_RAW8,        16, 1'b0, 1'b1, 1, 8,  0, 1, 0, 1'b0, "skew two"};
  rows[4] = '{7, 1, 0, DI_RAW8,        16, 1'b1, 1'b0, 1, 0,  0, 0, 1, 1'b0, "bad ecc"};
  rows[5] = '{7, 1, 1, DI_RAW8,        20, 1'b0, 1'b0, 1, 10, 0, 1, 0, 1'b0, "after bad ecc"};
  rows[6] = '{2, 6, 0, DI_FRAME_START, 1,  1'b0, 1'b0, 1, 0,  0, 0, 0, 1'b0, "second frame"};
  rows[7] = '{2, 6, 0, DI_RAW8,        16, 1'b0, 1'b0, 4, 8,  1, 1, 0, 1'b0, "slow credits"};
  rows[8] = '{2, 6, 1, DI_RAW8,        64, 1'b0, 1'b0, 0, 12, 0, 0, 0, 1'b1, "overflow"};
endtask

function automatic int run_time_limit();
  int sum;
  sum = 0;
  for( int r = 0; r < ROWS; r++ )
    sum += ( rows[r].wc + 100 ) * 10 * 4;
  return sum;
endfunction

// Raw bit n*8+j carries stream bit n*8+j-off, so the aligner needs (8-off)%8 slips.
function automatic byte_q_t rotate_lane( byte_q_t d, int off );
  byte_q_t    r;
  lane_byte_t b;
  lane_byte_t src;
  int         p;
  for( int n = 0; n < d.size(); n++ )
    begin
      for( int j = 0; j < 8; j++ )
        begin
          p = 8 * n + j - off;
          if( p < 0 )
            b[j] = 1'b0;
          else
            begin
              src  = d[p / 8];
              b[j] = src[p % 8];
            end
        end
      r.push_back( b );
    end
  return r;
endfunction

task automatic press_slips( input int off0, input int off1 );
  int need [LANE_COUNT];
  need[0] = ( ( 8 - off0 ) % 8 - cur_off[0] + 8 ) % 8;
  need[1] = ( ( 8 - off1 ) % 8 - cur_off[1] + 8 ) % 8;
  while( need[0] > 0 || need[1] > 0 )
    begin
      @( posedge ref_clk_i );
      btn_i <= { need[1] > 0, need[0] > 0 };
      repeat( 2 ) @( posedge ref_clk_i );
      btn_i <= '0;
      @( posedge ref_clk_i );
      for( int l = 0; l < LANE_COUNT; l++ )
        if( need[l] > 0 )
          need[l]--;
    end
  repeat( 5 ) @( posedge ref_clk_i );    // Slip pulse lands three cycles after the press.
  cur_off[0] = ( 8 - off0 ) % 8;
  cur_off[1] = ( 8 - off1 ) % 8;
endtask

task automatic run_row( input int r );
  row_t    t;
  byte_q_t pkt;
  byte_q_t lane [LANE_COUNT];
  byte_q_t raw0;
  byte_q_t raw1;
  ecc_t    ecc;
  int      w0;
  int      u0;
  int      l0;
  int      e0;
  int      err0;
  int      len;
  t = rows[r];
  press_slips( t.off0, t.off1 );

  ecc = csi2_ecc( { t.wc[15 : 8], t.wc[7 : 0], t.di } );
  pkt = '{t.di, t.wc[7 : 0], t.wc[15 : 8], { 2'b00, ecc }};
  if( t.corrupt )
    pkt[1] = pkt[1] ^ 8'h08;
  if( t.di == DI_RAW8 )
    begin
      if( !t.reuse )
        begin
          payload = {};
          for( int i = 0; i < t.wc; i++ )
            payload.push_back( lane_byte_t'( $urandom ) );
        end
      for( int i = 0; i < t.wc; i++ )
        pkt.push_back( payload[i] );
      pkt.push_back( 8'h5A );              // CRC is not checked by the receiver.
      pkt.push_back( 8'hC3 );
      // User on the first word of a frame, last on the final word of the line.
      for( int i = 0; i < t.exp_words; i++ )
        exp_q.push_back( { ( i == 0 && t.exp_user != 0 ), ( i == t.wc / 2 - 1 ),
                           payload[2 * i + 1], payload[2 * i] } );
    end

  for( int l = 0; l < LANE_COUNT; l++ )
    begin
      lane[l] = '{8'h00, 8'h00, SYNC_BYTE};
      for( int i = l; i < pkt.size(); i += LANE_COUNT )
        lane[l].push_back( pkt[i] );
      lane[l].push_back( 8'h00 );
      lane[l].push_back( 8'h00 );
    end
  raw0 = rotate_lane( lane[0], t.off0 );
  raw1 = rotate_lane( lane[1], t.off1 );
  len  = raw0.size();

  @( negedge ref_clk_i );
  w0            = words_total;
  u0            = user_total;
  l0            = last_total;
  e0            = ecc_total;
  err0          = errors;
  credit_hold   = ( t.period == 0 );
  credit_period = ( t.period == 0 ) ? 1 : t.period;

  for( int c = 0; c < len + t.skew; c++ )
    begin
      @( posedge ref_clk_i );
      lane_hs_valid_i[0] <= ( c < len );
      lane_raw_i[0]      <= ( c < len ) ? raw0[c] : 8'h00;
      lane_hs_valid_i[1] <= ( c >= t.skew );
      lane_raw_i[1]      <= ( c >= t.skew ) ? raw1[c - t.skew] : 8'h00;
    end
  @( posedge ref_clk_i );
  lane_hs_valid_i <= '0;
  lane_raw_i      <= '0;

  if( credit_hold )
    begin
      repeat( 20 ) @( posedge ref_clk_i );
      @( negedge ref_clk_i );
      credit_hold = 1'b0;
    end
  while( words_total - w0 < t.exp_words )
    @( posedge ref_clk_i );
  repeat( 20 ) @( posedge ref_clk_i );
  @( negedge ref_clk_i );

  compare_values( "word count", words_total - w0, t.exp_words );
  compare_values( "user flags", user_total - u0, t.exp_user );
  compare_values( "last flags", last_total - l0, t.exp_last );
  compare_values( "ecc errors", ecc_total - e0, t.exp_ecc );
  compare_values( "overflow_o", int'( overflow_o ), int'( t.exp_ovf ) );
  exp_q = {};
  $display( "Test %0d %s: %0d words, %0d errors", r, t.name, words_total - w0, errors - err0 );
endtask

// Output monitor and credit-returning sink.
always @( posedge ref_clk_i )
  if( !ref_srst_i )
    begin
      if( video_valid_o )
        begin
          if( exp_q.size() == 0 )
            begin
              $display( "Unexpected word 0x%0h came out at %0t", video_data_o, $time );
              errors++;
            end
          else
            compare_values( "output word",
                            int'( { video_user_o, video_last_o, video_data_o } ),
                            int'( exp_q.pop_front() ) );
          words_total++;
          user_total += int'( video_user_o );
          last_total += int'( video_last_o );
          owed++;
        end
      if( ecc_error_o )
        ecc_total++;
      compare_values( "valid beyond credits",
                      int'( words_total > int'( CREDIT_INIT ) + returned_total ), 0 );
      if( !credit_hold && owed != 0 && sink_cycle % credit_period == 0 )
        begin
          credit_return_i <= 1'b1;
          owed--;
          returned_total++;
        end
      else
        credit_return_i <= 1'b0;
      sink_cycle++;
    end

initial
  begin : watchdog
    int limit;
    #1;
    limit = run_time_limit();
    #( limit );
    $display( "Watchdog timeout: the run did not finish within %0d time units", limit );
    $display( "TESTS FAILED" );
    $finish;
  end

initial
  begin
    ref_srst_i      = 1'b1;
    btn_i           = '0;
    lane_raw_i      = '0;
    lane_hs_valid_i = '0;
    credit_return_i = 1'b0;
    credit_period   = 1;
    credit_hold     = 1'b0;
    errors          = 0;
    cur_off         = '{0, 0};
    void'( $urandom( 64060 ) );
    load_table();
    repeat( 2 ) @( posedge ref_clk_i );
    ref_srst_i <= 1'b0;
    repeat( 2 ) @( posedge ref_clk_i );
    for( int r = 0; r < ROWS; r++ )
      run_row( r );
    errors += UUT.credit_tx.credit_checks.fail_count;
    $display( "Summary: %0d tests run, %0d words received, %0d failed checks",
              ROWS, words_total, errors );
    if( errors == 0 )
      $display( "TESTS PASSED" );
    else
      $display( "TESTS FAILED" );
    $finish;
  end

endmodule

/* build.f */
verilog/csi2_pkg.sv
verilog/btn_edge_detect.sv
verilog/lane_bit_aligner.sv
verilog/lane_merger.sv
verilog/packet_parser.sv
verilog/credit_tx.sv
verilog/csi2_rx_top.sv
testbench/tb_clock_gen.sv
testbench/csi2_rx_assertions.sv
testbench/csi2_rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csi2_rx_tb
RTL_TOP   ?= csi2_rx_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
